/* rvSlice.f */
logic/rvPkg.sv
logic/ctrlIf.sv
logic/mainDecoder.sv
logic/aluDecoder.sv
logic/controller.sv
logic/regFile.sv
logic/alu.sv
logic/datapath.sv
logic/rvSlice.sv
testbench/clockGen.sv
testbench/rvSlice_assertions.sv
testbench/rvSlice_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = rvSlice_tb
FILELIST   = rvSlice.f
PASS_MSG   = Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* testbench/rvSlice_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvSlice_tb;

    localparam int maxCycles = 2000; // about 4x what the tests take.
    localparam int mixCount = 400;

    typedef logic [31:0] regArrT [32];

    typedef struct packed {
        logic        memWrite;
        logic        pcSrc;
        logic        chkTarget;
        logic        chkAlu;
        logic        wrEn;
        logic [4:0]  wrAddr;
        logic [31:0] pcTarget;
        logic [31:0] aluResult;
        logic [31:0] writeData;
        logic [31:0] wrVal;
    } expT;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] readData;
    logic        memWrite;
    logic        pcSrc;
    logic [31:0] pcTarget;
    logic [31:0] aluResult;
    logic [31:0] writeData;

    regArrT model;
    string  testName;
    integer seed;
    int     errors;
    int     checks;
    int     cycles;

    clockGen clkGen (
        .clk  (clk),
        .reset(reset)
    );

    rvSlice dut (.*);

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    function automatic logic [4:0] randReg(input logic nonZero);
        logic [31:0] r;
        r = rnd();
        if (nonZero && r[4:0] == 5'd0)
            r[4:0] = 5'd1;
        randReg = r[4:0];
    endfunction

    function automatic logic [2:0] funct3Of(input rvPkg::aluCtrlT fn);
        case (fn)
            rvPkg::aluSlt: funct3Of = 3'b010;
            rvPkg::aluOr:  funct3Of = 3'b110;
            rvPkg::aluAnd: funct3Of = 3'b111;
            default:       funct3Of = 3'b000;
        endcase
    endfunction

    // instruction word in the format its opcode implies.
    function automatic logic [31:0] encode(input rvPkg::opcodeT op, input rvPkg::aluCtrlT fn,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [31:0] imm);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = (fn == rvPkg::aluSub) ? 7'b0100000 : 7'b0000000;
        f3 = funct3Of(fn);
        case (op)
            rvPkg::opRtype:  encode = {f7, rs2, rs1, f3, rd, op};
            rvPkg::opItype:  encode = {imm[11:0], rs1, f3, rd, op};
            rvPkg::opLoad:   encode = {imm[11:0], rs1, 3'b010, rd, op};
            rvPkg::opStore:  encode = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op};
            rvPkg::opBranch: encode = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], op};
            default:         encode = {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
        endcase
    endfunction

    function automatic logic [31:0] ruleOp(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b010:  ruleOp = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  ruleOp = a | b;
            3'b111:  ruleOp = a & b;
            default: ruleOp = sub ? a - b : a + b;
        endcase
    endfunction

    // instruction-level model of one cycle.
    function automatic expT expectOut(input logic [31:0] ins, input logic [31:0] pcIn,
                                      input logic [31:0] rdIn, input regArrT regs);
        expT e;
        logic [31:0] a;
        logic [31:0] immI;
        a = regs[ins[19:15]];
        immI = {{20{ins[31]}}, ins[31:20]};
        e = '0;
        e.writeData = regs[ins[24:20]];
        e.wrAddr = ins[11:7];
        e.chkAlu = 1'b1;
        e.wrEn = 1'b1;
        case (ins[6:0])
            rvPkg::opLoad: begin
                e.aluResult = a + immI;
                e.wrVal = rdIn;
            end
            rvPkg::opStore: begin
                e.memWrite = 1'b1;
                e.aluResult = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                e.wrEn = 1'b0;
            end
            rvPkg::opRtype: begin
                e.aluResult = ruleOp(ins[14:12], ins[30], a, e.writeData);
                e.wrVal = e.aluResult;
            end
            rvPkg::opItype: begin
                e.aluResult = ruleOp(ins[14:12], 1'b0, a, immI);
                e.wrVal = e.aluResult;
            end
            rvPkg::opBranch: begin
                e.pcSrc = (a == e.writeData);
                e.pcTarget = pcIn + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                e.chkTarget = 1'b1;
                e.chkAlu = 1'b0;
                e.wrEn = 1'b0;
            end
            rvPkg::opJal: begin
                e.pcSrc = 1'b1;
                e.pcTarget = pcIn + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                e.chkTarget = 1'b1;
                e.chkAlu = 1'b0;
                e.wrVal = pcIn + 32'd4;
            end
            default: begin
                e.chkAlu = 1'b0;
                e.wrEn = 1'b0;
            end
        endcase
        if (e.wrAddr == 5'd0)
            e.wrEn = 1'b0; // x0 stays zero.
        expectOut = e;
    endfunction

    task automatic logMismatch(input string field, input logic [31:0] expVal,
                               input logic [31:0] actVal);
        errors++;
        $display("Error %s %s: expected %h actual %h", testName, field, expVal, actVal);
    endtask

    always @(negedge clk) begin : compare
        expT e;
        if (!reset) begin
            e = expectOut(instr, pc, readData, model);
            checks++;
            if (memWrite !== e.memWrite)
                logMismatch("memWrite", 32'(e.memWrite), 32'(memWrite));
            if (pcSrc !== e.pcSrc)
                logMismatch("pcSrc", 32'(e.pcSrc), 32'(pcSrc));
            if (writeData !== e.writeData)
                logMismatch("writeData", e.writeData, writeData);
            if (e.chkAlu && aluResult !== e.aluResult)
                logMismatch("aluResult", e.aluResult, aluResult);
            if (e.chkTarget && pcTarget !== e.pcTarget)
                logMismatch("pcTarget", e.pcTarget, pcTarget);
            if (e.wrEn)
                model[e.wrAddr] = e.wrVal; // dut writes on the coming edge.
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= maxCycles) begin
            $display("timeout: the tests did not finish within %0d cycles", maxCycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic apply(input string name, input logic [31:0] ins);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = rnd();
        r2 = rnd();
        @(posedge clk);
        #1;
        testName = name;
        instr = ins;
        pc = {r1[31:2], 2'b00};
        readData = r2;
    endtask

    // writes rd, then reads it back through a store.
    task automatic writeAndStore(input string name, input rvPkg::opcodeT op,
                                 input rvPkg::aluCtrlT fn, input int count);
        logic [4:0] rd;
        repeat (count) begin
            rd = randReg(1'b1);
            apply(name, encode(op, fn, rd, randReg(1'b0), randReg(1'b0), rnd()));
            apply(name, encode(rvPkg::opStore, rvPkg::aluAdd, 5'd0, randReg(1'b0), rd, rnd()));
        end
    endtask

    initial begin : stimulus
        logic [31:0]     r;
        logic [4:0]      rs;
        rvPkg::opcodeT   op;
        rvPkg::aluCtrlT  fn;
        seed = 32'hceb981cf;
        errors = 0;
        checks = 0;
        cycles = 0;
        instr = '0;
        pc = '0;
        readData = '0;
        testName = "reset";
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        @(negedge reset);

        repeat (8)
            apply("swAfterReset",
                  encode(rvPkg::opStore, rvPkg::aluAdd, 5'd0, randReg(1'b0), randReg(1'b0), rnd()));
        writeAndStore("addi", rvPkg::opItype, rvPkg::aluAdd, 6);
        writeAndStore("andi", rvPkg::opItype, rvPkg::aluAnd, 4);
        writeAndStore("ori", rvPkg::opItype, rvPkg::aluOr, 4);
        writeAndStore("slti", rvPkg::opItype, rvPkg::aluSlt, 4);
        writeAndStore("add", rvPkg::opRtype, rvPkg::aluAdd, 4);
        writeAndStore("sub", rvPkg::opRtype, rvPkg::aluSub, 4);
        writeAndStore("and", rvPkg::opRtype, rvPkg::aluAnd, 4);
        writeAndStore("or", rvPkg::opRtype, rvPkg::aluOr, 4);
        writeAndStore("slt", rvPkg::opRtype, rvPkg::aluSlt, 4);
        writeAndStore("lw", rvPkg::opLoad, rvPkg::aluAdd, 8);
        apply("lwX0", encode(rvPkg::opLoad, rvPkg::aluAdd, 5'd0, randReg(1'b0), 5'd0, rnd()));
        apply("lwX0", encode(rvPkg::opStore, rvPkg::aluAdd, 5'd0, randReg(1'b0), 5'd0, rnd()));

        for (int i = 0; i < 12; i++) begin
            rs = randReg(1'b0);
            apply("beq", encode(rvPkg::opBranch, rvPkg::aluAdd, 5'd0, rs,
                                i[0] ? randReg(1'b0) : rs, rnd())); // even i forces equal.
        end
        writeAndStore("jal", rvPkg::opJal, rvPkg::aluAdd, 4);
        repeat (4) begin
            r = rnd();
            apply("unknownOp", {r[31:7], r[0] ? 7'b0001011 : 7'b1111111});
        end

        repeat (mixCount) begin
            r = rnd();
            case (r[3:0])
                4'd0, 4'd1:       op = rvPkg::opLoad;
                4'd2, 4'd3:       op = rvPkg::opStore;
                4'd4, 4'd5, 4'd6: op = rvPkg::opRtype;
                4'd7, 4'd8, 4'd9: op = rvPkg::opItype;
                4'd10, 4'd11:     op = rvPkg::opBranch;
                default:          op = rvPkg::opJal;
            endcase
            case (r[6:4])
                3'd0:    fn = rvPkg::aluSub;
                3'd1:    fn = rvPkg::aluAnd;
                3'd2:    fn = rvPkg::aluOr;
                3'd3:    fn = rvPkg::aluSlt;
                default: fn = rvPkg::aluAdd;
            endcase
            apply("randomMix", encode(op, fn, randReg(1'b0), randReg(1'b0), randReg(1'b0), rnd()));
        end

        @(negedge clk);
        #1;
        $display("cycles checked: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rvSlice_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rvSlice_assertions (
    input logic                   clk,
    input logic                   reset,
    input logic [rvPkg::xlen-1:0] instr,
    input logic                   memWrite,
    input logic                   pcSrc,
    input logic [rvPkg::xlen-1:0] pcTarget,
    input logic [rvPkg::xlen-1:0] aluResult,
    input logic [rvPkg::xlen-1:0] writeData
);

    logic knownOp;

    assign knownOp = instr[6:0] inside {rvPkg::opLoad, rvPkg::opStore, rvPkg::opRtype,
                                        rvPkg::opItype, rvPkg::opBranch, rvPkg::opJal};

    storeNotBranch: assert property (@(posedge clk) disable iff (reset)
        !(memWrite && pcSrc))
        else $error("memWrite and pcSrc are high together");

    unknownOpQuiet: assert property (@(posedge clk) disable iff (reset)
        !knownOp |-> (!memWrite && !pcSrc))
        else $error("unknown opcode raised memWrite or pcSrc");

    outputsKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({memWrite, pcSrc, pcTarget, aluResult, writeData}))
        else $error("an output is unknown after reset");

endmodule

bind rvSlice rvSlice_assertions sliceChecks (
    .clk      (clk),
    .reset    (reset),
    .instr    (instr),
    .memWrite (memWrite),
    .pcSrc    (pcSrc),
    .pcTarget (pcTarget),
    .aluResult(aluResult),
    .writeData(writeData)
);

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    localparam int halfPeriod = 4; // 8 ns period.

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0; // released off the edge.
    end

endmodule

`default_nettype wire

/* logic/rvSlice.sv */
`timescale 1ns/1ps
`default_nettype none

module rvSlice (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [rvPkg::xlen-1:0] instr,
    input  logic [rvPkg::xlen-1:0] pc,
    input  logic [rvPkg::xlen-1:0] readData,
    output logic                   memWrite,
    output logic                   pcSrc,
    output logic [rvPkg::xlen-1:0] pcTarget,
    output logic [rvPkg::xlen-1:0] aluResult,
    output logic [rvPkg::xlen-1:0] writeData
);

    ctrlIf ctrlBus ();

    controller ctrlUnit (
        .instr   (instr),
        .memWrite(memWrite),
        .pcSrc   (pcSrc),
        .ctrl    (ctrlBus.ctrl)
    );

    datapath dpUnit (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .pc       (pc),
        .readData (readData),
        .ctrl     (ctrlBus.dp),
        .pcTarget (pcTarget),
        .aluResult(aluResult),
        .writeData(writeData)
    );

endmodule

`default_nettype wire

/* logic/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [rvPkg::xlen-1:0] instr,
    input  logic [rvPkg::xlen-1:0] pc,
    input  logic [rvPkg::xlen-1:0] readData,
    ctrlIf.dp                      ctrl,
    output logic [rvPkg::xlen-1:0] pcTarget,
    output logic [rvPkg::xlen-1:0] aluResult,
    output logic [rvPkg::xlen-1:0] writeData
);

    logic [rvPkg::xlen-1:0] immExt;
    logic [rvPkg::xlen-1:0] srcA;
    logic [rvPkg::xlen-1:0] srcB;
    logic [rvPkg::xlen-1:0] pcPlus4;
    logic [rvPkg::xlen-1:0] result;

    always_comb begin
        case (ctrl.immSrc)
            rvPkg::immS: immExt = {{(rvPkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::immB: immExt = {{(rvPkg::xlen-12){instr[31]}}, instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
            rvPkg::immJ: immExt = {{(rvPkg::xlen-20){instr[31]}}, instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
            default:     immExt = {{(rvPkg::xlen-12){instr[31]}}, instr[31:20]};
        endcase
    end

    regFile regs (
        .clk        (clk),
        .reset      (reset),
        .writeEnable(ctrl.regWrite),
        .readAddr1  (instr[19:15]),
        .readAddr2  (instr[24:20]),
        .writeAddr  (instr[11:7]),
        .writeData  (result),
        .readData1  (srcA),
        .readData2  (writeData)
    );

    assign srcB = ctrl.aluSrc ? immExt : writeData; // rs2 or immediate.

    alu aluUnit (
        .srcA      (srcA),
        .srcB      (srcB),
        .aluControl(ctrl.aluControl),
        .result    (aluResult),
        .zero      (ctrl.zero)
    );

    assign pcPlus4  = pc + rvPkg::xlen'(4);
    assign pcTarget = pc + immExt;

    always_comb begin
        case (ctrl.resultSrc)
            rvPkg::resMem:     result = readData;
            rvPkg::resPcPlus4: result = pcPlus4; // jal link.
            default:           result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rvPkg::xlen-1:0] srcA,
    input  logic [rvPkg::xlen-1:0] srcB,
    input  rvPkg::aluCtrlT         aluControl,
    output logic [rvPkg::xlen-1:0] result,
    output logic                   zero
);

    always_comb begin
        case (aluControl)
            rvPkg::aluAdd: result = srcA + srcB;
            rvPkg::aluSub: result = srcA - srcB;
            rvPkg::aluAnd: result = srcA & srcB;
            rvPkg::aluOr:  result = srcA | srcB;
            rvPkg::aluSlt: begin
                // signed compare.
                if ($signed(srcA) < $signed(srcB))
                    result = rvPkg::xlen'(1);
                else
                    result = '0;
            end
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       writeEnable,
    input  logic [rvPkg::regAddrW-1:0] readAddr1,
    input  logic [rvPkg::regAddrW-1:0] readAddr2,
    input  logic [rvPkg::regAddrW-1:0] writeAddr,
    input  logic [rvPkg::xlen-1:0]     writeData,
    output logic [rvPkg::xlen-1:0]     readData1,
    output logic [rvPkg::xlen-1:0]     readData2
);

    logic [rvPkg::xlen-1:0] regs [rvPkg::regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rvPkg::regCount; i++)
                regs[i] <= '0;
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData; // x0 never written.
        end
    end

    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

`default_nettype wire

/* logic/controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  logic [rvPkg::xlen-1:0] instr,
    output logic                   memWrite,
    output logic                   pcSrc,
    ctrlIf.ctrl                    ctrl
);

    logic         branch;
    logic         jump;
    rvPkg::aluOpT aluOp;

    mainDecoder mainDec (
        .opcode   (rvPkg::opcodeT'(instr[6:0])),
        .regWrite (ctrl.regWrite),
        .aluSrc   (ctrl.aluSrc),
        .memWrite (memWrite),
        .branch   (branch),
        .jump     (jump),
        .immSrc   (ctrl.immSrc),
        .resultSrc(ctrl.resultSrc),
        .aluOp    (aluOp)
    );

    aluDecoder aluDec (
        .aluOp     (aluOp),
        .funct3    (instr[14:12]),
        .funct7b5  (instr[30]),
        .opb5      (instr[5]),
        .aluControl(ctrl.aluControl)
    );

    assign pcSrc = jump | (branch & ctrl.zero); // taken beq or jal.

endmodule

`default_nettype wire

/* logic/aluDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
    input  rvPkg::aluOpT   aluOp,
    input  logic [2:0]     funct3,
    input  logic           funct7b5,
    input  logic           opb5,
    output rvPkg::aluCtrlT aluControl
);

    always_comb begin
        case (aluOp)
            rvPkg::aluOpAdd: aluControl = rvPkg::aluAdd;
            rvPkg::aluOpSub: aluControl = rvPkg::aluSub;
            rvPkg::aluOpFunct: begin
                case (funct3)
                    3'b000: begin
                        // only R-type sub has both bits set
                        if (funct7b5 && opb5)
                            aluControl = rvPkg::aluSub;
                        else
                            aluControl = rvPkg::aluAdd;
                    end
                    3'b010:  aluControl = rvPkg::aluSlt;
                    3'b110:  aluControl = rvPkg::aluOr;
                    3'b111:  aluControl = rvPkg::aluAnd;
                    default: aluControl = rvPkg::aluAdd; // unsupported funct3.
                endcase
            end
            default: aluControl = rvPkg::aluAdd;
        endcase
    end

endmodule

`default_nettype wire

/* logic/mainDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
    input  rvPkg::opcodeT    opcode,
    output logic             regWrite,
    output logic             aluSrc,
    output logic             memWrite,
    output logic             branch,
    output logic             jump,
    output rvPkg::immSrcT    immSrc,
    output rvPkg::resultSrcT resultSrc,
    output rvPkg::aluOpT     aluOp
);

    always_comb begin
        // everything inactive unless the opcode says otherwise
        regWrite  = 1'b0;
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        immSrc    = rvPkg::immI;
        resultSrc = rvPkg::resAlu;
        aluOp     = rvPkg::aluOpAdd;
        case (opcode)
            rvPkg::opLoad: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = rvPkg::resMem;   // load data back.
            end
            rvPkg::opStore: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immSrc   = rvPkg::immS;
            end
            rvPkg::opRtype: begin
                regWrite = 1'b1;
                aluOp    = rvPkg::aluOpFunct;
            end
            rvPkg::opItype: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = rvPkg::aluOpFunct;
            end
            rvPkg::opBranch: begin
                branch = 1'b1;
                immSrc = rvPkg::immB;
                aluOp  = rvPkg::aluOpSub;    // compare by subtract.
            end
            rvPkg::opJal: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immSrc    = rvPkg::immJ;
                resultSrc = rvPkg::resPcPlus4; // link address.
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/ctrlIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
    logic              regWrite;
    rvPkg::immSrcT     immSrc;
    logic              aluSrc;     // immediate as second operand.
    rvPkg::resultSrcT  resultSrc;
    rvPkg::aluCtrlT    aluControl;
    logic              zero;

    modport ctrl (output regWrite, immSrc, aluSrc, resultSrc, aluControl,
                  input zero);

    modport dp (input regWrite, immSrc, aluSrc, resultSrc, aluControl,
                output zero);
endinterface

`default_nettype wire

/* logic/rvPkg.sv */
`default_nettype none

package rvPkg;

    localparam int xlen = 32;
    localparam int regCount = 32;
    localparam int regAddrW = $clog2(regCount);

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRtype  = 7'b0110011,
        opItype  = 7'b0010011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeT;

    typedef enum logic [1:0] {
        immI,
        immS,
        immB,
        immJ
    } immSrcT;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPcPlus4
    } resultSrcT;

    typedef enum logic [1:0] {
        aluOpAdd,
        aluOpSub,
        aluOpFunct
    } aluOpT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluCtrlT;

endpackage

`default_nettype wire
